// ==== hw/isaPkg.sv ====
`default_nettype none

package isaPkg;

	typedef logic [31:0] wordT;
	typedef logic [31:0] instrT;
	typedef logic [4:0] regAddrT;
	typedef logic [15:0] immT;
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	// Primary opcodes
	localparam opcodeT SPECIAL = 6'b000000;  // R-type, function field selects op
	localparam opcodeT ADDI = 6'b001000;
	localparam opcodeT ADDIU = 6'b001001;
	localparam opcodeT ANDI = 6'b001100;
	localparam opcodeT ORI = 6'b001101;

	// Function codes under SPECIAL
	localparam functT ADD = 6'b100000;
	localparam functT ADDU = 6'b100001;
	localparam functT SUB = 6'b100010;
	localparam functT SUBU = 6'b100011;
	localparam functT AND = 6'b100100;
	localparam functT OR = 6'b100101;
	localparam functT SLT = 6'b101010;

	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_LSB = 0;

endpackage

`default_nettype wire

// ==== hw/execPkg.sv ====
`default_nettype none

package execPkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOpT;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_EXEC,
		ST_WRITE
	} execStateT;

	// Packed micro-op {aluOp, srcA, srcB, dest, imm, useImm}, 3+5+5+5+16+1 bits
	typedef logic [34:0] uopT;

endpackage

`default_nettype wire

// ==== hw/opPushIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface opPushIf
	import isaPkg::*, execPkg::*;
();

	logic load;  // One-cycle pulse, only while full is low
	logic full;
	aluOpT aluOp;
	regAddrT srcA;
	regAddrT srcB;
	regAddrT dest;
	immT imm;
	logic useImm;  // Immediate replaces srcB

	modport decoderSide(
		output load, aluOp, srcA, srcB, dest, imm, useImm,
		input full
	);

	modport queueSide(
		input load, aluOp, srcA, srcB, dest, imm, useImm,
		output full
	);

endinterface

`default_nettype wire

// ==== hw/opPopIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface opPopIf
	import isaPkg::*, execPkg::*;
();

	logic empty;
	logic take;  // Pulse removes the head entry
	aluOpT aluOp;
	regAddrT srcA;
	regAddrT srcB;
	regAddrT dest;
	immT imm;
	logic useImm;

	modport queueSide(
		output empty, aluOp, srcA, srcB, dest, imm, useImm,
		input take
	);

	modport executorSide(
		input empty, aluOp, srcA, srcB, dest, imm, useImm,
		output take
	);

endinterface

`default_nettype wire

// ==== hw/instrDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrDecoder
	import isaPkg::*, execPkg::*;
(
	input logic clk,
	input logic rst,
	input logic instrStrobe,
	input instrT instr,
	output logic busy,
	output logic halted,
	opPushIf.decoderSide push
);

	opcodeT opcode;
	functT funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	immT imm;
	aluOpT decAluOp;
	logic decUseImm;
	logic legal;
	logic holdValid;
	logic accept;

	assign opcode = instr[OPCODE_LSB +: $bits(opcodeT)];
	assign funct = instr[FUNCT_LSB +: $bits(functT)];
	assign rs = instr[RS_LSB +: $bits(regAddrT)];
	assign rt = instr[RT_LSB +: $bits(regAddrT)];
	assign rd = instr[RD_LSB +: $bits(regAddrT)];
	assign imm = instr[IMM_LSB +: $bits(immT)];

	always_comb
	begin
		legal = 1'b1;
		decAluOp = ALU_ADD;
		decUseImm = 1'b0;
		case (opcode)
			SPECIAL:
			begin
				case (funct)
					ADD, ADDU: decAluOp = ALU_ADD;
					SUB, SUBU: decAluOp = ALU_SUB;
					AND: decAluOp = ALU_AND;
					OR: decAluOp = ALU_OR;
					SLT: decAluOp = ALU_SLT;
					default: legal = 1'b0;
				endcase
			end
			ADDI, ADDIU: decUseImm = 1'b1;
			ANDI:
			begin
				decAluOp = ALU_AND;
				decUseImm = 1'b1;
			end
			ORI:
			begin
				decAluOp = ALU_OR;
				decUseImm = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	assign accept = instrStrobe && !holdValid && !halted;
	assign busy = holdValid;
	assign push.load = holdValid && !push.full;  // Waits out a full queue

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			holdValid <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			if (accept && !legal)
				halted <= 1'b1;  // Sticky until reset
			if (accept && legal)
				holdValid <= 1'b1;
			else if (push.load)
				holdValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			push.aluOp <= decAluOp;
			push.srcA <= rs;
			push.srcB <= rt;
			push.dest <= decUseImm ? rt : rd;  // I-type writes rt
			push.imm <= imm;
			push.useImm <= decUseImm;
		end
	end

endmodule

`default_nettype wire

// ==== hw/opQueue.sv ====
`timescale 1ns/100ps
`default_nettype none

module opQueue
	import execPkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input logic clk,
	input logic rst,
	opPushIf.queueSide push,
	opPopIf.queueSide pop
);

	localparam int IDX_W = $clog2(QUEUE_DEPTH);

	uopT mem [QUEUE_DEPTH];
	uopT head;
	logic [IDX_W:0] wrPtr;  // Extra bit tells full from empty
	logic [IDX_W:0] rdPtr;

	assign push.full = (wrPtr[IDX_W] != rdPtr[IDX_W]) &&
		(wrPtr[IDX_W-1:0] == rdPtr[IDX_W-1:0]);
	assign pop.empty = (wrPtr == rdPtr);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (push.load)
				wrPtr <= wrPtr + 1'b1;
			if (pop.take)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push.load)
			mem[wrPtr[IDX_W-1:0]] <= {push.aluOp, push.srcA, push.srcB, push.dest,
				push.imm, push.useImm};
	end

	// Show-ahead head entry
	assign head = mem[rdPtr[IDX_W-1:0]];
	assign pop.aluOp = aluOpT'(head[34:32]);
	assign pop.srcA = head[31:27];
	assign pop.srcB = head[26:22];
	assign pop.dest = head[21:17];
	assign pop.imm = head[16:1];
	assign pop.useImm = head[0];

endmodule

`default_nettype wire

// ==== hw/aluExecutor.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluExecutor
	import isaPkg::*, execPkg::*;
(
	input logic clk,
	input logic rst,
	opPopIf.executorSide pop,
	output logic wbStrobe,
	output regAddrT wbAddr,
	output wordT wbData
);

	execStateT state;
	wordT regs [32];
	aluOpT curOp;
	regAddrT curSrcA;
	regAddrT curSrcB;
	regAddrT curDest;
	immT curImm;
	logic curUseImm;
	wordT immExt;
	wordT opA;
	wordT opB;
	wordT aluOut;
	wordT result;

	assign pop.take = (state == ST_IDLE) && !pop.empty;

	// Sign extension only for add
	assign immExt = (curOp == ALU_ADD) ? {{16{curImm[15]}}, curImm} : {16'b0, curImm};

	always_comb
	begin
		case (curOp)
			ALU_ADD: aluOut = opA + opB;
			ALU_SUB: aluOut = opA - opB;
			ALU_AND: aluOut = opA & opB;
			ALU_OR: aluOut = opA | opB;
			ALU_SLT: aluOut = {31'b0, $signed(opA) < $signed(opB)};
			default: aluOut = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= ST_IDLE;
			regs <= '{default: '0};
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (pop.take)
						state <= ST_READ;
				end
				ST_READ: state <= ST_EXEC;
				ST_EXEC: state <= ST_WRITE;
				ST_WRITE:
				begin
					state <= ST_IDLE;
					if (curDest != '0)
						regs[curDest] <= result;  // r0 stays zero
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && pop.take)
		begin
			curOp <= pop.aluOp;  // Entry leaves the queue on this edge
			curSrcA <= pop.srcA;
			curSrcB <= pop.srcB;
			curDest <= pop.dest;
			curImm <= pop.imm;
			curUseImm <= pop.useImm;
		end
		if (state == ST_READ)
		begin
			opA <= regs[curSrcA];
			opB <= curUseImm ? immExt : regs[curSrcB];
		end
		if (state == ST_EXEC)
			result <= aluOut;
	end

	assign wbStrobe = (state == ST_WRITE);
	assign wbAddr = curDest;
	assign wbData = result;

endmodule

`default_nettype wire

// ==== hw/coreTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module coreTop
	import isaPkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input logic clk,
	input logic rst,
	input logic instrStrobe,
	input instrT instr,
	output logic busy,
	output logic halted,
	output logic wbStrobe,
	output regAddrT wbAddr,
	output wordT wbData
);

	opPushIf pushBus();
	opPopIf popBus();

	instrDecoder decoder_i (
		.clk(clk),
		.rst(rst),
		.instrStrobe(instrStrobe),
		.instr(instr),
		.busy(busy),
		.halted(halted),
		.push(pushBus.decoderSide)
	);

	opQueue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue_i (
		.clk(clk),
		.rst(rst),
		.push(pushBus.queueSide),
		.pop(popBus.queueSide)
	);

	aluExecutor executor_i (
		.clk(clk),
		.rst(rst),
		.pop(popBus.executorSide),
		.wbStrobe(wbStrobe),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

endmodule

`default_nettype wire

// ==== dv/coreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module coreTb
	import isaPkg::*;
();

	localparam int SEED = 32'had66;
	localparam int NUM_RR = 40;
	localparam int NUM_LOGIC_IMM = 12;
	localparam int NUM_BURST = 16;
	localparam int TOTAL_INSTR = 31 + NUM_RR + NUM_LOGIC_IMM + 4 + NUM_BURST + 11;
	localparam int TIMEOUT_CYCLES = 8 * TOTAL_INSTR + 200;

	typedef struct packed {
		regAddrT dest;
		wordT value;
	} expT;

	logic clk;
	logic rst;
	logic instrStrobe;
	instrT instr;
	logic busy;
	logic halted;
	logic wbStrobe;
	regAddrT wbAddr;
	wordT wbData;

	wordT model [32];
	expT expQ [$];
	expT expItem;
	logic haltExpected;
	int errorCount;
	int testCount;
	int testStartErrors;
	string testName;
	int cycles;

	coreTop #(
		.QUEUE_DEPTH(4)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.instrStrobe(instrStrobe),
		.instr(instr),
		.busy(busy),
		.halted(halted),
		.wbStrobe(wbStrobe),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	function automatic instrT encodeR(input functT fn, input regAddrT rd, input regAddrT rs,
		input regAddrT rt);
		return {SPECIAL, rs, rt, rd, 5'b0, fn};
	endfunction

	function automatic instrT encodeI(input opcodeT op, input regAddrT rt, input regAddrT rs,
		input immT imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instrT randomInstr(input logic regOnly);
		functT fns [7];
		opcodeT ops [4];
		regAddrT rd;
		regAddrT rs;
		regAddrT rt;
		fns = '{ADD, ADDU, SUB, SUBU, AND, OR, SLT};
		ops = '{ADDI, ADDIU, ANDI, ORI};
		rd = regAddrT'($urandom_range(31, 1));
		rs = regAddrT'($urandom_range(31, 0));
		rt = regAddrT'($urandom_range(31, 0));
		if (regOnly || $urandom_range(1, 0) == 1)
			return encodeR(fns[$urandom_range(6, 0)], rd, rs, rt);
		return encodeI(ops[$urandom_range(3, 0)], rd, rs, immT'($urandom));
	endfunction

	// Expected destination and value of one instruction
	function automatic void computeResult(input instrT ins, input wordT regs [32],
		output regAddrT dest, output wordT value);
		regAddrT rs;
		regAddrT rt;
		wordT a;
		wordT b;
		rs = ins[25:21];
		rt = ins[20:16];
		a = (rs == '0) ? '0 : regs[rs];
		b = (rt == '0) ? '0 : regs[rt];
		dest = rt;  // I-type target
		value = '0;
		case (opcodeT'(ins[31:26]))
			SPECIAL:
			begin
				dest = ins[15:11];
				case (functT'(ins[5:0]))
					ADD, ADDU: value = a + b;
					SUB, SUBU: value = a - b;
					AND: value = a & b;
					OR: value = a | b;
					SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: value = '0;
				endcase
			end
			ADDI, ADDIU: value = a + {{16{ins[15]}}, ins[15:0]};
			ANDI: value = a & {16'h0, ins[15:0]};
			ORI: value = a | {16'h0, ins[15:0]};
			default: value = '0;
		endcase
	endfunction

	task automatic checkValue(input string what, input wordT actual, input wordT expected);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			errorCount++;
		end
	endtask

	// Called on a falling edge, returns on the next one
	task automatic sendInstr(input instrT ins, input logic legal);
		regAddrT dest;
		wordT value;
		logic accepted;
		while (busy)
			@(negedge clk);
		instrStrobe = 1'b1;
		instr = ins;
		accepted = legal && !haltExpected;
		if (accepted)
		begin
			computeResult(ins, model, dest, value);
			if (dest != '0)
				model[dest] = value;
			expQ.push_back({dest, value});
		end
		if (!legal)
			haltExpected = 1'b1;
		@(negedge clk);
		instrStrobe = 1'b0;
		checkValue("busy after strobe", 32'(busy), 32'(accepted));  // Held entry keeps busy high
	endtask

	task automatic waitForResults(input int extraCycles);
		while (expQ.size() != 0)
			@(negedge clk);
		repeat (extraCycles)
			@(negedge clk);
	endtask

	task automatic startTest(input string name);
		testName = name;
		testStartErrors = errorCount;
		testCount++;
	endtask

	task automatic finishTest();
		$display("Test %0d (%s) finished with %0d errors", testCount, testName,
			errorCount - testStartErrors);
	endtask

	// Write-back checker
	always @(negedge clk)
	begin
		if (rst && wbStrobe)
		begin
			if (expQ.size() == 0)
			begin
				$display("Unexpected write-back to r%0d at %0t ns, no result was pending",
					wbAddr, $time);
				errorCount++;
			end
			else
			begin
				expItem = expQ.pop_front();
				checkValue("wbAddr", 32'(wbAddr), 32'(expItem.dest));
				checkValue("wbData", wbData, expItem.value);
			end
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the run did not finish", cycles);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		immT imm;
		int i;
		void'($urandom(SEED));
		rst = 1'b0;
		instrStrobe = 1'b0;
		instr = '0;
		model = '{default: '0};
		haltExpected = 1'b0;
		errorCount = 0;
		testCount = 0;
		repeat (10)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		startTest("immediate loads");
		for (i = 1; i < 32; i++)
		begin
			imm = immT'($urandom);
			imm[15] = i[0];  // Odd registers get negative values
			sendInstr(encodeI(ADDIU, regAddrT'(i), '0, imm), 1'b1);
		end
		waitForResults(2);
		finishTest();

		startTest("register-register");
		for (i = 0; i < NUM_RR; i++)
			sendInstr(randomInstr(1'b1), 1'b1);
		waitForResults(2);
		finishTest();

		startTest("zero-extended immediates");
		for (i = 0; i < NUM_LOGIC_IMM; i++)
		begin
			imm = immT'($urandom) | 16'h8000;
			sendInstr(encodeI(i[0] ? ORI : ANDI, regAddrT'($urandom_range(31, 1)),
				regAddrT'($urandom_range(31, 0)), imm), 1'b1);
		end
		waitForResults(2);
		finishTest();

		startTest("register zero");
		sendInstr(encodeR(ADDU, '0, 5'd5, 5'd6), 1'b1);
		sendInstr(encodeI(ORI, '0, 5'd3, 16'hF0F0), 1'b1);
		sendInstr(encodeR(ADDU, 5'd7, '0, '0), 1'b1);
		sendInstr(encodeR(ADDU, 5'd8, '0, 5'd3), 1'b1);
		waitForResults(2);
		finishTest();

		startTest("back-pressure burst");
		for (i = 0; i < NUM_BURST; i++)
			sendInstr(randomInstr(1'b0), 1'b1);
		waitForResults(2);
		finishTest();

		startTest("illegal word");
		for (i = 0; i < 6; i++)
			sendInstr(randomInstr(1'b0), 1'b1);
		sendInstr({6'b100011, 26'h0A5_5A5A}, 1'b0);  // LW opcode, not supported
		checkValue("halted after illegal word", 32'(halted), 32'd1);
		for (i = 0; i < 4; i++)
			sendInstr(randomInstr(1'b0), 1'b1);
		repeat (8 * 11)  // Window for this test's strobes
			@(negedge clk);
		checkValue("halted at end", 32'(halted), 32'd1);
		checkValue("pending results", 32'(expQ.size()), 32'd0);
		finishTest();

		$display("Summary: %0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/isaPkg.sv
hw/execPkg.sv
hw/opPushIf.sv
hw/opPopIf.sv
hw/instrDecoder.sv
hw/opQueue.sv
hw/aluExecutor.sv
hw/coreTop.sv
dv/coreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	-f vlog.f --top-module coreTb -o coreSim

./obj_dir/coreSim | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation did not pass, see sim.log"
	exit 1
fi
